/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_tcdm_group_interco
FILELIST = tcdm_group_interco.f
LOG      = sim.log

.PHONY: sim clean

# Build and run, then look for the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* logic/stream_rr_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter over valid/ready streams
// Locks its grant while the output is stalled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module stream_rr_arbiter #(
  parameter int unsigned NumIn     = 4,
  parameter type         payload_t = logic
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  payload_t [NumIn-1:0]     data_i,
  input  logic     [NumIn-1:0]     valid_i,
  output logic     [NumIn-1:0]     ready_o,
  output payload_t                 data_o,
  output logic                     valid_o,
  input  logic                     ready_i
);

  localparam int unsigned IdxW = (NumIn > 1) ? $clog2(NumIn) : 1;

  typedef logic [IdxW-1:0] idx_t;

  idx_t rr_q;
  idx_t sel_q;
  logic lock_q;
  idx_t arb_idx;
  idx_t sel;

  // First valid input at or after the pointer
  always_comb begin
    int unsigned base;
    int unsigned cand;
    logic        found;
    base    = rr_q;
    found   = 1'b0;
    arb_idx = rr_q;
    for (int unsigned i = 0; i < NumIn; i++) begin
      cand = (base + i) % NumIn;
      if (!found && valid_i[cand]) begin
        found   = 1'b1;
        arb_idx = idx_t'(cand);
      end
    end
  end

  assign sel     = lock_q ? sel_q : arb_idx;
  assign valid_o = lock_q ? valid_i[sel_q] : |valid_i;
  assign data_o  = data_i[sel];

  always_comb begin
    ready_o      = '0;
    ready_o[sel] = valid_o & ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q   <= '0;
      sel_q  <= '0;
      lock_q <= 1'b0;
    end else if (valid_o) begin
      if (ready_i) begin
        rr_q   <= (sel == idx_t'(NumIn - 1)) ? '0 : sel + 1'b1;
        lock_q <= 1'b0;
      end else begin
        // Stalled, hold this grant
        sel_q  <= sel;
        lock_q <= 1'b1;
      end
    end
  end

  a_ready_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(ready_o))
    else $error("stream_rr_arbiter: more than one input granted");

  a_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("stream_rr_arbiter: output changed while stalled");

endmodule

`default_nettype wire

/* logic/tcdm_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage, one tile's bank with
// a registered response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "tcdm_group_defs.svh"

module tcdm_bank
  import tcdm_group_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  bank_req_t  req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output bank_resp_t resp_o,
  output logic       resp_valid_o,
  input  logic       resp_ready_i
);

  data_t      mem_q [`GROUP_BANK_WORDS];
  data_t      old_word;
  data_t      merged_word;
  bank_resp_t resp_q;
  logic       resp_valid_q;
  logic       accept;

  // Free slot, or the held response leaves this cycle
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  assign old_word = mem_q[req_i.row];

  // Byte merge of write data over the stored word
  always_comb begin
    merged_word = old_word;
    for (int unsigned i = 0; i < $bits(strb_t); i++) begin
      if (req_i.be[i]) begin
        merged_word[8*i +: 8] = req_i.wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && req_i.wen) begin
      mem_q[req_i.row] <= merged_word;
    end
  end

  // Writes answer with the word after the merge
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q.ini   <= req_i.ini;
      resp_q.rdata <= req_i.wen ? merged_word : old_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o))
    else $error("tcdm_bank: response changed under back-pressure");

endmodule

`default_nettype wire

/* logic/tcdm_group_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM group sizing macros
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TCDM_GROUP_DEFS_SVH
`define TCDM_GROUP_DEFS_SVH

// Tiles in the group, one bank per tile
`define GROUP_NUM_TILES 4

// Width of one data word
`define GROUP_DATA_WIDTH 32

// Width of a word address
`define GROUP_ADDR_WIDTH 16

// Words held by each bank
`define GROUP_BANK_WORDS 64

`endif

/* logic/tcdm_group_interco.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Local TCDM interconnect of one group
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "tcdm_group_defs.svh"

module tcdm_group_interco
  import tcdm_group_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  tcdm_req_t  [`GROUP_NUM_TILES-1:0] req_i,
  input  logic       [`GROUP_NUM_TILES-1:0] req_valid_i,
  output logic       [`GROUP_NUM_TILES-1:0] req_ready_o,
  output tcdm_resp_t [`GROUP_NUM_TILES-1:0] resp_o,
  output logic       [`GROUP_NUM_TILES-1:0] resp_valid_o,
  input  logic       [`GROUP_NUM_TILES-1:0] resp_ready_i
);

  localparam int unsigned N = `GROUP_NUM_TILES;

  bank_req_t  [N-1:0]        dec_req;
  logic       [N-1:0][N-1:0] dec_valid;     // [tile][bank]
  logic       [N-1:0][N-1:0] dec_ready;     // [tile][bank]
  logic       [N-1:0][N-1:0] arb_valid;     // [bank][tile]
  logic       [N-1:0][N-1:0] arb_ready;     // [bank][tile]
  bank_req_t  [N-1:0]        bank_req;
  logic       [N-1:0]        bank_req_valid;
  logic       [N-1:0]        bank_req_ready;
  bank_resp_t [N-1:0]        bank_resp;
  logic       [N-1:0]        bank_resp_valid;
  logic       [N-1:0]        bank_resp_ready;

  tcdm_req_decode i_decode (
    .req_i       (req_i      ),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .bank_req_o  (dec_req    ),
    .bank_valid_o(dec_valid  ),
    .bank_ready_i(dec_ready  )
  );

  for (genvar b = 0; b < N; b++) begin : gen_banks
    for (genvar t = 0; t < N; t++) begin : gen_xpose
      assign arb_valid[b][t] = dec_valid[t][b];
      assign dec_ready[t][b] = arb_ready[b][t];
    end

    stream_rr_arbiter #(
      .NumIn    (N         ),
      .payload_t(bank_req_t)
    ) i_req_arb (
      .clk_i  (clk_i            ),
      .reset_i(reset_i          ),
      .data_i (dec_req          ),
      .valid_i(arb_valid[b]     ),
      .ready_o(arb_ready[b]     ),
      .data_o (bank_req[b]      ),
      .valid_o(bank_req_valid[b]),
      .ready_i(bank_req_ready[b])
    );

    tcdm_bank i_bank (
      .clk_i       (clk_i             ),
      .reset_i     (reset_i           ),
      .req_i       (bank_req[b]       ),
      .req_valid_i (bank_req_valid[b] ),
      .req_ready_o (bank_req_ready[b] ),
      .resp_o      (bank_resp[b]      ),
      .resp_valid_o(bank_resp_valid[b]),
      .resp_ready_i(bank_resp_ready[b])
    );
  end

  tcdm_resp_route i_resp_route (
    .clk_i       (clk_i          ),
    .reset_i     (reset_i        ),
    .bank_resp_i (bank_resp      ),
    .bank_valid_i(bank_resp_valid),
    .bank_ready_o(bank_resp_ready),
    .resp_o      (resp_o         ),
    .resp_valid_o(resp_valid_o   ),
    .resp_ready_i(resp_ready_i   )
  );

endmodule

`default_nettype wire

/* logic/tcdm_group_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM group types for requests and responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "tcdm_group_defs.svh"

package tcdm_group_pkg;

  typedef logic [$clog2(`GROUP_NUM_TILES)-1:0]  tile_idx_t;
  typedef logic [`GROUP_ADDR_WIDTH-1:0]         tcdm_addr_t;
  typedef logic [$clog2(`GROUP_BANK_WORDS)-1:0] bank_row_t;
  typedef logic [`GROUP_DATA_WIDTH-1:0]         data_t;
  typedef logic [`GROUP_DATA_WIDTH/8-1:0]       strb_t;

  // Request as issued by a tile
  typedef struct packed {
    tcdm_addr_t addr;
    logic       wen;
    data_t      wdata;
    strb_t      be;
  } tcdm_req_t;

  // Request as seen by a bank, tagged with its initiator
  typedef struct packed {
    bank_row_t  row;
    tile_idx_t  ini;
    logic       wen;
    data_t      wdata;
    strb_t      be;
  } bank_req_t;

  typedef struct packed {
    tile_idx_t  ini;
    data_t      rdata;
  } bank_resp_t;

  typedef struct packed {
    data_t      rdata;
  } tcdm_resp_t;

endpackage

`default_nettype wire

/* logic/tcdm_req_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage, steers tile requests to banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "tcdm_group_defs.svh"

module tcdm_req_decode
  import tcdm_group_pkg::*;
(
  input  tcdm_req_t [`GROUP_NUM_TILES-1:0]                         req_i,
  input  logic      [`GROUP_NUM_TILES-1:0]                         req_valid_i,
  output logic      [`GROUP_NUM_TILES-1:0]                         req_ready_o,
  output bank_req_t [`GROUP_NUM_TILES-1:0]                         bank_req_o,
  // Indexed [tile][bank]
  output logic      [`GROUP_NUM_TILES-1:0][`GROUP_NUM_TILES-1:0]   bank_valid_o,
  input  logic      [`GROUP_NUM_TILES-1:0][`GROUP_NUM_TILES-1:0]   bank_ready_i
);

  localparam int unsigned TileW = $bits(tile_idx_t);
  localparam int unsigned RowW  = $bits(bank_row_t);

  tile_idx_t [`GROUP_NUM_TILES-1:0] tgt;

  for (genvar t = 0; t < `GROUP_NUM_TILES; t++) begin : gen_tiles
    // Interleaved: low bits pick the bank, next bits the row
    assign tgt[t] = req_i[t].addr[TileW-1:0];

    assign bank_req_o[t].row   = req_i[t].addr[TileW +: RowW];
    assign bank_req_o[t].ini   = tile_idx_t'(t);
    assign bank_req_o[t].wen   = req_i[t].wen;
    assign bank_req_o[t].wdata = req_i[t].wdata;
    assign bank_req_o[t].be    = req_i[t].be;

    for (genvar b = 0; b < `GROUP_NUM_TILES; b++) begin : gen_banks
      assign bank_valid_o[t][b] = req_valid_i[t] && (tgt[t] == tile_idx_t'(b));
    end

    assign req_ready_o[t] = bank_ready_i[t][tgt[t]];

    always_comb begin
      assert ($onehot0(bank_valid_o[t]))
        else $error("tcdm_req_decode: tile %0d steered to several banks", t);
    end
  end

endmodule

`default_nettype wire

/* logic/tcdm_resp_route.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result stage, returns bank responses
// to the tiles that asked
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "tcdm_group_defs.svh"

module tcdm_resp_route
  import tcdm_group_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  bank_resp_t [`GROUP_NUM_TILES-1:0]       bank_resp_i,
  input  logic       [`GROUP_NUM_TILES-1:0]       bank_valid_i,
  output logic       [`GROUP_NUM_TILES-1:0]       bank_ready_o,
  output tcdm_resp_t [`GROUP_NUM_TILES-1:0]       resp_o,
  output logic       [`GROUP_NUM_TILES-1:0]       resp_valid_o,
  input  logic       [`GROUP_NUM_TILES-1:0]       resp_ready_i
);

  // Indexed [tile][bank]
  logic       [`GROUP_NUM_TILES-1:0][`GROUP_NUM_TILES-1:0] tile_valid;
  logic       [`GROUP_NUM_TILES-1:0][`GROUP_NUM_TILES-1:0] tile_ready;
  bank_resp_t [`GROUP_NUM_TILES-1:0]                       tile_resp;

  for (genvar t = 0; t < `GROUP_NUM_TILES; t++) begin : gen_tiles
    for (genvar b = 0; b < `GROUP_NUM_TILES; b++) begin : gen_banks
      assign tile_valid[t][b] = bank_valid_i[b] && (bank_resp_i[b].ini == tile_idx_t'(t));
    end

    stream_rr_arbiter #(
      .NumIn    (`GROUP_NUM_TILES),
      .payload_t(bank_resp_t     )
    ) i_resp_arb (
      .clk_i  (clk_i          ),
      .reset_i(reset_i        ),
      .data_i (bank_resp_i    ),
      .valid_i(tile_valid[t]  ),
      .ready_o(tile_ready[t]  ),
      .data_o (tile_resp[t]   ),
      .valid_o(resp_valid_o[t]),
      .ready_i(resp_ready_i[t])
    );

    // Initiator index is dropped on the way out
    assign resp_o[t].rdata = tile_resp[t].rdata;
  end

  // Only the named tile can grant, so an OR is enough
  always_comb begin
    bank_ready_o = '0;
    for (int unsigned t = 0; t < `GROUP_NUM_TILES; t++) begin
      bank_ready_o = bank_ready_o | tile_ready[t];
    end
  end

endmodule

`default_nettype wire

/* tcdm_group_interco.f */
+incdir+logic
logic/tcdm_group_pkg.sv
logic/stream_rr_arbiter.sv
logic/tcdm_req_decode.sv
logic/tcdm_bank.sv
logic/tcdm_resp_route.sv
logic/tcdm_group_interco.sv
test/tb_tcdm_group_interco.sv

/* test/tb_tcdm_group_interco.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the group TCDM interconnect
// Reference memory model and assertion checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "tcdm_group_defs.svh"

module tb_tcdm_group_interco
  import tcdm_group_pkg::*;
();

  localparam int unsigned N            = `GROUP_NUM_TILES;
  localparam int unsigned BankWords    = `GROUP_BANK_WORDS;
  localparam int unsigned MemWords     = N * BankWords;
  localparam int unsigned AddrBits     = $clog2(MemWords);
  localparam int unsigned Timeout      = 200;
  localparam int unsigned PhaseTimeout = 5000;
  localparam int unsigned RandomOps    = 40;

  logic              clk_i;
  logic              reset_i;
  tcdm_req_t [N-1:0] req_i;
  logic      [N-1:0] req_valid_i;
  logic      [N-1:0] req_ready_o;
  tcdm_resp_t [N-1:0] resp_o;
  logic      [N-1:0] resp_valid_o;
  logic      [N-1:0] resp_ready_i;

  data_t       ref_mem [MemWords];
  data_t       exp_q [N];
  data_t       hold_q [N];
  logic [N-1:0] pend_q;
  int unsigned wait_cnt [N];
  logic        bp_en;
  int unsigned done_cnt;
  string       test_name;

  tcdm_group_interco i_dut (
    .clk_i       (clk_i       ),
    .reset_i     (reset_i     ),
    .req_i       (req_i       ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .resp_o      (resp_o      ),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i)
  );

  always #2 clk_i = ~clk_i;

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t be);
    data_t res;
    res = old_w;
    for (int i = 0; i < $bits(strb_t); i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Bank that takes a request from tile t this cycle, N if none
  function automatic int unsigned served_bank(input int t);
    int unsigned res;
    res = N;
    for (int b = 0; b < N; b++) begin
      if (i_dut.bank_req_valid[b] && i_dut.bank_req_ready[b] &&
          i_dut.bank_req[b].ini == tile_idx_t'(t)) begin
        res = b;
      end
    end
    return res;
  endfunction

  task automatic value_error(input string check, input data_t exp_v, input data_t act_v);
    $display("** Error [%s] %s: expected %h actual %h", test_name, check, exp_v, act_v);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic timeout_fail(input int t, input string what);
    $display("Timeout in %s: tile %0d never saw its %s", test_name, t, what);
    $display("sim failed");
    $fatal(1);
  endtask

  // Reference model, updated on every accepted request
  always @(posedge clk_i) begin
    int unsigned idx;
    int unsigned b;
    data_t       word;
    for (int t = 0; t < N; t++) begin
      hold_q[t] <= resp_o[t].rdata;
      b = int'(req_i[t].addr[$bits(tile_idx_t)-1:0]);
      if (reset_i) begin
        pend_q[t]   <= 1'b0;
        wait_cnt[t] <= 0;
      end else if (req_valid_i[t] && req_ready_o[t]) begin
        idx  = int'(req_i[t].addr[AddrBits-1:0]);
        word = ref_mem[idx];
        if (req_i[t].wen) begin
          word = merge_bytes(word, req_i[t].wdata, req_i[t].be);
          ref_mem[idx] <= word;
        end
        exp_q[t]    <= word;
        pend_q[t]   <= 1'b1;
        wait_cnt[t] <= 0;
      end else begin
        if (resp_valid_o[t] && resp_ready_i[t]) begin
          pend_q[t] <= 1'b0;
        end
        if (!req_valid_i[t]) begin
          wait_cnt[t] <= 0;
        end else if (i_dut.bank_req_valid[b] && i_dut.bank_req_ready[b]) begin
          // Target bank served another tile
          wait_cnt[t] <= wait_cnt[t] + 1;
        end
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk_i) $fell(reset_i) |-> resp_valid_o == '0)
    else value_error("reset_idle", '0, data_t'(resp_valid_o));

  for (genvar t = 0; t < N; t++) begin : gen_checks
    a_resp_data: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_valid_o[t] && resp_ready_i[t] |-> resp_o[t].rdata == exp_q[t])
      else value_error("resp_data", exp_q[t], resp_o[t].rdata);

    a_no_stray: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_valid_o[t] |-> pend_q[t])
      else value_error("no_stray", 32'd1, data_t'(pend_q[t]));

    a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_valid_o[t] && !resp_ready_i[t] |=> resp_valid_o[t] && resp_o[t].rdata == hold_q[t])
      else value_error("backpressure", hold_q[t], resp_o[t].rdata);

    // Low address bits pick the bank that must take the request
    a_steer: assert property (@(posedge clk_i) disable iff (reset_i)
      req_valid_i[t] && req_ready_o[t] |-> served_bank(t) == req_i[t].addr % N)
      else value_error("steering", data_t'(req_i[t].addr % N), data_t'(served_bank(t)));

    a_fair: assert property (@(posedge clk_i) disable iff (reset_i)
      req_valid_i[t] |-> wait_cnt[t] < N)
      else value_error("fairness", data_t'(N - 1), data_t'(wait_cnt[t]));
  end

  // Random back-pressure on the response side
  always @(negedge clk_i) begin
    if (bp_en) begin
      for (int t = 0; t < N; t++) begin
        resp_ready_i[t] = ($urandom % 4) != 0;
      end
    end
  end

  task automatic send_req(input int t, input tcdm_addr_t a, input logic we,
                          input data_t wd, input strb_t be_v);
    int unsigned cycles;
    @(negedge clk_i);
    req_i[t]       = '{addr: a, wen: we, wdata: wd, be: be_v};
    req_valid_i[t] = 1'b1;
    cycles = 0;
    while (!pend_q[t]) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) timeout_fail(t, "request accept");
    end
    req_valid_i[t] = 1'b0;
    cycles = 0;
    while (pend_q[t]) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) timeout_fail(t, "response");
    end
  endtask

  task automatic tile_job(input int t, input int kind);
    tcdm_addr_t a;
    case (kind)
      0: begin
        // Fill pattern from the whole address
        for (int i = 0; i < BankWords; i++) begin
          a = tcdm_addr_t'(t * BankWords + i);
          send_req(t, a, 1'b1, {a, a ^ 16'h5a5a}, '1);
        end
      end
      1: begin
        // Every tile hits bank 2, distinct rows
        a = tcdm_addr_t'(((t + 8) << 2) | 2);
        send_req(t, a, 1'b1, data_t'($urandom), '1);
        send_req(t, a, 1'b0, '0, '0);
      end
      default: begin
        for (int i = 0; i < RandomOps; i++) begin
          a = tcdm_addr_t'($urandom % MemWords);
          send_req(t, a, 1'($urandom % 2), data_t'($urandom), strb_t'($urandom));
        end
      end
    endcase
    done_cnt++;
  endtask

  task automatic run_phase(input int kind);
    int unsigned cycles;
    done_cnt = 0;
    for (int t = 0; t < N; t++) begin
      automatic int tt = t;
      fork
        tile_job(tt, kind);
      join_none
    end
    cycles = 0;
    while (done_cnt < N) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > PhaseTimeout) timeout_fail(-1, "phase end");
    end
  endtask

  initial begin
    void'($urandom(32'hce83));
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    req_i        = '0;
    req_valid_i  = '0;
    resp_ready_i = '1;
    bp_en        = 1'b0;
    done_cnt     = 0;
    test_name    = "reset";
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;

    test_name = "fill";
    run_phase(0);
    bp_en = 1'b1;

    test_name = "write_read";
    send_req(0, 16'h0005, 1'b1, 32'h11223344, 4'b1111);
    send_req(0, 16'h0005, 1'b1, 32'haabbccdd, 4'b0101);
    send_req(0, 16'h0005, 1'b0, '0, '0);

    test_name = "interleave";
    send_req(1, 16'h0020, 1'b1, 32'hcafef00d, 4'b1100);
    send_req(3, 16'h0020, 1'b0, '0, '0);
    for (int i = 0; i < N; i++) begin
      send_req(2, tcdm_addr_t'(16'h0040 + i), 1'b1, data_t'(32'h1000 + i), '1);
    end

    test_name = "contention";
    run_phase(1);

    test_name = "random";
    run_phase(2);

    repeat (4) @(negedge clk_i);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
